/* verilog.f */
src/fetch_pkg.sv
src/icache_mem.sv
src/icache_ctrl.sv
src/fetch_stage.sv
src/fetch_buffer.sv
src/fetch_top.sv
sim/fetch_checker.sv
sim/tb_fetch.sv

/* sim/tb_fetch.sv */
module tb_fetch import fetch_pkg::*; ();

  localparam int dispatch_timeout = 5000;   // Cycles per wait

  logic     clock             = 1'b0;
  logic     rst_n             = 1'b0;
  mem_tag_t mem2proc_response = '0;
  mem_tag_t mem2proc_tag      = '0;
  block_t   mem2proc_data     = '0;
  logic     redirect          = 1'b0;
  addr_t    redirect_pc       = '0;
  logic     take              = 1'b0;
  bus_cmd_e proc2mem_command;
  addr_t    proc2mem_addr;
  logic     out_valid;
  addr_t    out_pc;
  inst_t    out_ir;

  int       test_num    = 0;
  logic     test_end    = 1'b0;
  logic     report      = 1'b0;
  int       fail_tests;
  int       err_total;
  integer   seed        = 32'hb812;
  int       accept_of_4 = 3;   // Memory takes a request in this many of 4 cycles
  int       stall_pct   = 20;
  int       stall_len   = 4;
  mem_tag_t next_tag    = 4'd1;
  mem_tag_t pend_tag    = '0;
  addr_t    pend_addr   = '0;
  int       reply_wait  = 0;
  int       stretch     = 0;

  fetch_top dut (
    .clock             (clock),
    .rst_n             (rst_n),
    .mem2proc_response (mem2proc_response),
    .mem2proc_data     (mem2proc_data),
    .mem2proc_tag      (mem2proc_tag),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .redirect          (redirect),
    .redirect_pc       (redirect_pc),
    .take              (take),
    .out_valid         (out_valid),
    .out_pc            (out_pc),
    .out_ir            (out_ir)
  );

  fetch_checker checker_0 (.*);

  always #50 clock = ~clock;

  function automatic inst_t mem_word(input addr_t a);
    logic [31:0] prod;
    prod = a[31:0] * 32'h9e3779b9;
    return prod + 32'h1234;
  endfunction

  // Response offered every cycle and counts only under bus_load
  always @(posedge clock) begin : mem_model
    mem_tag_t offer;
    offer = next_tag;
    if (!rst_n) begin
      mem2proc_response <= '0;
      mem2proc_tag      <= '0;
      reply_wait        <= 0;
      next_tag          <= 4'd1;
    end else begin
      mem2proc_tag <= '0;
      if (reply_wait == 1) begin
        mem2proc_tag  <= pend_tag;
        mem2proc_data <= {mem_word(pend_addr + 64'd4), mem_word(pend_addr)};
      end
      if (reply_wait != 0) reply_wait <= reply_wait - 1;
      if (proc2mem_command == bus_load && mem2proc_response != '0) begin
        pend_tag   <= mem2proc_response;
        pend_addr  <= proc2mem_addr;
        reply_wait <= 1 + {$random(seed)} % 8;
        offer = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
        next_tag   <= offer;
      end
      mem2proc_response <= ({$random(seed)} % 4 < accept_of_4) ? offer : 4'd0;
    end
  end

  // Dispatch consumer with random take stretches
  always @(posedge clock) begin
    if (!rst_n) begin
      take    <= 1'b0;
      stretch <= 0;
    end else if (stretch != 0) begin
      stretch <= stretch - 1;
    end else begin
      take    <= ({$random(seed)} % 100) >= stall_pct;
      stretch <= {$random(seed)} % stall_len;
    end
  end

  task automatic wait_dispatches(input int n, output logic ok);
    int got;
    int cycles;
    got    = 0;
    cycles = 0;
    while (got < n && cycles < dispatch_timeout) begin
      @(posedge clock);
      cycles++;
      if (out_valid && take) got++;
    end
    ok = (got >= n);
    if (!ok) begin
      $display("Timeout in test %0d: only %0d of %0d instructions dispatched in %0d cycles",
               test_num, got, n, cycles);
    end
  endtask

  task automatic redirect_to(input addr_t target);
    @(posedge clock);
    redirect    <= 1'b1;
    redirect_pc <= target;
    @(posedge clock);
    redirect    <= 1'b0;
  endtask

  task automatic run_phase(input int num, input int accept, input int pct, input int len,
                           input logic odd, output logic ok);
    addr_t target;
    @(posedge clock);
    test_num    <= num;
    accept_of_4 <= accept;
    stall_pct   <= pct;
    stall_len   <= len;
    wait_dispatches(40, ok);
    if (ok) begin
      target = addr_t'({$random(seed)} & 32'h0000_fffc);   // Word aligned, below 64 KB
      if (odd) target[2] = 1'b1;
      redirect_to(target);
      wait_dispatches(24, ok);
    end
    if (ok) begin
      @(posedge clock);
      test_end <= 1'b1;
      @(posedge clock);
      test_end <= 1'b0;
    end
  endtask

  initial begin : main
    logic ok;
    repeat (10) @(posedge clock);
    rst_n <= 1'b1;
    run_phase(1, 3, 20, 4, 1'b0, ok);
    if (ok) run_phase(2, 1, 20, 4, 1'b0, ok);    // Memory refuses most requests
    if (ok) run_phase(3, 3, 60, 24, 1'b0, ok);
    if (ok) run_phase(4, 3, 20, 4, 1'b1, ok);
    if (ok) begin
      @(posedge clock);
      report <= 1'b1;
      @(posedge clock);
      report <= 1'b0;
      @(negedge clock);
    end
    if (ok && fail_tests == 0 && err_total == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* sim/fetch_checker.sv */
module fetch_checker import fetch_pkg::*; (
  input  logic     clock,
  input  logic     rst_n,
  input  bus_cmd_e proc2mem_command,
  input  addr_t    proc2mem_addr,
  input  mem_tag_t mem2proc_response,
  input  mem_tag_t mem2proc_tag,
  input  logic     redirect,
  input  addr_t    redirect_pc,
  input  logic     take,
  input  logic     out_valid,
  input  addr_t    out_pc,
  input  inst_t    out_ir,
  input  int       test_num,
  input  logic     test_end,
  input  logic     report,
  output int       fail_tests,
  output int       err_total
);

  addr_t                expect_pc;
  logic                 was_reset;
  logic                 after_redirect;
  int                   test_errs;
  int                   test_disp;
  int                   pass_tests;
  cache_tag_t           tbl_tag [num_lines];   // Mirror of the cache tags
  logic [num_lines-1:0] tbl_valid;
  mem_tag_t             fill_tag;               // Zero when no load is pending
  cache_idx_t           fill_idx;
  cache_tag_t           fill_ctag;

  // Word at byte address a is low 32 bits of a * 9e3779b9 plus 1234
  function automatic inst_t expected_ir(input addr_t pc);
    logic [31:0] prod;
    prod = pc[31:0] * 32'h9e3779b9;
    return prod + 32'h1234;
  endfunction

  function automatic string test_name(input int n);
    case (n)
      1:       return "sequential fetch";
      2:       return "busy memory";
      3:       return "dispatch back-pressure";
      4:       return "odd-word redirect";
      default: return "unnamed";
    endcase
  endfunction

  task automatic report_err(input string msg);
    $display("ERR %0t: %s", $time, msg);
    test_errs++;
    err_total++;
  endtask

  always @(posedge clock) begin
    if (!rst_n) begin
      expect_pc      = reset_pc;
      was_reset      = 1'b1;
      after_redirect = 1'b0;
      tbl_valid      = '0;
      fill_tag       = '0;
      test_errs      = 0;
      test_disp      = 0;
      pass_tests     = 0;
      fail_tests     = 0;
      err_total      = 0;
    end else begin
      if (was_reset && (proc2mem_command != bus_none || out_valid))
        report_err("bus command or out_valid active in the first cycle after reset");
      was_reset = 1'b0;
      if (after_redirect && out_valid)
        report_err("out_valid high in the cycle after a redirect");
      after_redirect = 1'b0;

      if (out_valid && take) begin
        test_disp++;
        if (out_pc != expect_pc)
          report_err($sformatf("out_pc %h, expected %h", out_pc, expect_pc));
        if (out_ir != expected_ir(out_pc))
          report_err($sformatf("out_ir %h at pc %h, expected %h",
                               out_ir, out_pc, expected_ir(out_pc)));
        expect_pc = {48'h0, out_pc[15:0] + 16'd4};   // 64 KB wrap
      end

      if (proc2mem_command == bus_load) begin
        if (tbl_valid[proc2mem_addr[7:3]] && tbl_tag[proc2mem_addr[7:3]] == proc2mem_addr[15:8])
          report_err($sformatf("bus_load for block %h that is already cached", proc2mem_addr));
        if (proc2mem_addr[63:16] != '0 || proc2mem_addr[2:0] != '0)
          report_err($sformatf("bus address %h not a block in 64 KB", proc2mem_addr));
        if (mem2proc_response != '0) begin
          fill_tag  = mem2proc_response;
          fill_idx  = proc2mem_addr[7:3];
          fill_ctag = proc2mem_addr[15:8];
        end
      end else if (fill_tag != '0 && mem2proc_tag == fill_tag) begin
        tbl_valid[fill_idx] = 1'b1;
        tbl_tag[fill_idx]   = fill_ctag;
        fill_tag            = '0;
      end

      if (redirect) begin
        expect_pc      = redirect_pc;
        after_redirect = 1'b1;
      end

      if (test_end) begin
        if (test_errs == 0) pass_tests++;
        else fail_tests++;
        $display("test %0d %s: %0d dispatched, %0d errors, %s", test_num, test_name(test_num),
                 test_disp, test_errs, (test_errs == 0) ? "ok" : "failed");
        test_errs = 0;
        test_disp = 0;
      end
      if (report)
        $display("tests passed %0d, failed %0d, errors %0d", pass_tests, fail_tests, err_total);
    end
  end

endmodule

/* src/fetch_top.sv */
module fetch_top import fetch_pkg::*; (
  input  logic     clock,
  input  logic     rst_n,
  input  mem_tag_t mem2proc_response,
  input  block_t   mem2proc_data,
  input  mem_tag_t mem2proc_tag,
  output bus_cmd_e proc2mem_command,
  output addr_t    proc2mem_addr,
  input  logic     redirect,
  input  addr_t    redirect_pc,
  input  logic     take,
  output logic     out_valid,
  output addr_t    out_pc,
  output inst_t    out_ir
);

  // Cache array wires
  block_t     rd_data;
  logic       rd_valid;
  cache_idx_t rd_idx;
  cache_idx_t wr_idx;
  cache_tag_t rd_tag;
  cache_tag_t wr_tag;
  logic       wr_en;

  // Fetch path
  addr_t                   fetch_addr;
  block_t                  block_data;
  logic                    block_valid;
  logic  [fetch_width-1:0] ins_valid;
  addr_t [fetch_width-1:0] ins_pc;
  inst_t [fetch_width-1:0] ins_ir;
  logic                    has_room;

  icache_mem icache_mem_0 (
    .clock    (clock),
    .rst_n    (rst_n),
    .wr_en    (wr_en),
    .wr_idx   (wr_idx),
    .wr_tag   (wr_tag),
    .wr_data  (mem2proc_data),   // Fill straight from the bus
    .rd_idx   (rd_idx),
    .rd_tag   (rd_tag),
    .rd_data  (rd_data),
    .rd_valid (rd_valid)
  );

  icache_ctrl icache_ctrl_0 (
    .clock             (clock),
    .rst_n             (rst_n),
    .fetch_addr        (fetch_addr),
    .mem2proc_response (mem2proc_response),
    .mem2proc_tag      (mem2proc_tag),
    .mem2proc_data     (mem2proc_data),
    .rd_data           (rd_data),
    .rd_valid          (rd_valid),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .block_data        (block_data),
    .block_valid       (block_valid),
    .rd_idx            (rd_idx),
    .wr_idx            (wr_idx),
    .rd_tag            (rd_tag),
    .wr_tag            (wr_tag),
    .wr_en             (wr_en)
  );

  fetch_stage fetch_stage_0 (
    .clock       (clock),
    .rst_n       (rst_n),
    .block_data  (block_data),
    .block_valid (block_valid),
    .has_room    (has_room),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .fetch_addr  (fetch_addr),
    .ins_valid   (ins_valid),
    .ins_pc      (ins_pc),
    .ins_ir      (ins_ir)
  );

  fetch_buffer fetch_buffer_0 (
    .clock     (clock),
    .rst_n     (rst_n),
    .ins_valid (ins_valid),
    .ins_pc    (ins_pc),
    .ins_ir    (ins_ir),
    .redirect  (redirect),
    .take      (take),
    .has_room  (has_room),
    .out_valid (out_valid),
    .out_pc    (out_pc),
    .out_ir    (out_ir)
  );

endmodule

/* src/fetch_buffer.sv */
module fetch_buffer import fetch_pkg::*; (
  input  logic                    clock,
  input  logic                    rst_n,
  input  logic  [fetch_width-1:0] ins_valid,
  input  addr_t [fetch_width-1:0] ins_pc,
  input  inst_t [fetch_width-1:0] ins_ir,
  input  logic                    redirect,
  input  logic                    take,
  output logic                    has_room,
  output logic                    out_valid,
  output addr_t                   out_pc,
  output inst_t                   out_ir
);

  addr_t pc_q [fb_depth];
  inst_t ir_q [fb_depth];

  fb_ptr_t                   head;
  fb_ptr_t                   tail;
  fb_cnt_t                   count;
  fb_cnt_t                   ins_cnt;
  fb_ptr_t [fetch_width-1:0] wr_ptr;
  logic                      pop;

  // Valid slots pack in order from the tail
  always_comb begin
    ins_cnt = '0;
    for (int i = 0; i < fetch_width; i++) begin
      wr_ptr[i] = tail + fb_ptr_t'(ins_cnt);
      if (ins_valid[i]) begin
        ins_cnt = ins_cnt + fb_cnt_t'(1);
      end
    end
  end

  assign has_room  = count <= fb_cnt_t'(fb_depth - fetch_width);
  assign out_valid = count != '0;
  assign out_pc    = pc_q[head];
  assign out_ir    = ir_q[head];
  assign pop       = out_valid && take;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else if (redirect) begin
      head  <= '0;   // Flush old path
      tail  <= '0;
      count <= '0;
    end else begin
      head  <= head + fb_ptr_t'(pop);
      tail  <= tail + fb_ptr_t'(ins_cnt);
      count <= count + ins_cnt - fb_cnt_t'(pop);
    end
  end

  always_ff @(posedge clock) begin
    for (int i = 0; i < fetch_width; i++) begin
      if (ins_valid[i] && !redirect) begin
        pc_q[wr_ptr[i]] <= ins_pc[i];
        ir_q[wr_ptr[i]] <= ins_ir[i];
      end
    end
  end

  a_count_bound: assert property (@(posedge clock) disable iff (!rst_n)
    count <= fb_cnt_t'(fb_depth))
    else $error("fetch_buffer: occupancy above depth");

  // Fetch must respect the room it was given
  a_insert_room: assert property (@(posedge clock) disable iff (!rst_n)
    (ins_valid != '0) |-> has_room)
    else $error("fetch_buffer: insertion without room");

endmodule

/* src/fetch_stage.sv */
module fetch_stage import fetch_pkg::*; (
  input  logic                    clock,
  input  logic                    rst_n,
  input  block_t                  block_data,
  input  logic                    block_valid,
  input  logic                    has_room,
  input  logic                    redirect,
  input  addr_t                   redirect_pc,
  output addr_t                   fetch_addr,
  output logic  [fetch_width-1:0] ins_valid,
  output addr_t [fetch_width-1:0] ins_pc,
  output inst_t [fetch_width-1:0] ins_ir
);

  addr_t pc;
  addr_t next_block_pc;
  logic  advance;

  assign fetch_addr = pc;

  // No insertion in the redirect cycle
  assign advance = block_valid && has_room && !redirect;

  // Next block boundary, wrapping inside the 64 KB space
  assign next_block_pc = {48'h0, pc[15:3] + 13'd1, 3'b000};

  // Split the block; words below the PC are skipped
  always_comb begin
    for (int i = 0; i < fetch_width; i++) begin
      ins_pc[i]    = {pc[63:3], 3'b000} + addr_t'(4 * i);
      ins_ir[i]    = block_data[32*i +: 32];
      ins_valid[i] = advance && (i >= int'(pc[2]));
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      pc <= reset_pc;
    end else if (redirect) begin
      pc <= redirect_pc;
    end else if (advance) begin
      pc <= next_block_pc;
    end
  end

endmodule

/* src/icache_ctrl.sv */
module icache_ctrl import fetch_pkg::*; (
  input  logic       clock,
  input  logic       rst_n,
  input  addr_t      fetch_addr,
  input  mem_tag_t   mem2proc_response,
  input  mem_tag_t   mem2proc_tag,
  input  block_t     mem2proc_data,
  input  block_t     rd_data,
  input  logic       rd_valid,
  output bus_cmd_e   proc2mem_command,
  output addr_t      proc2mem_addr,
  output block_t     block_data,
  output logic       block_valid,
  output cache_idx_t rd_idx,
  output cache_idx_t wr_idx,
  output cache_tag_t rd_tag,
  output cache_tag_t wr_tag,
  output logic       wr_en
);

  ctrl_state_e state;
  ctrl_state_e next_state;
  cache_idx_t  miss_idx;
  cache_tag_t  miss_tag;
  mem_tag_t    pend_tag;     // Tag memory gave the outstanding load
  logic        miss;
  logic        accepted;
  logic        fill_match;

  assign rd_idx = fetch_addr[7:3];
  assign rd_tag = fetch_addr[15:8];

  // Fill always goes to the latched miss line
  assign wr_idx = miss_idx;
  assign wr_tag = miss_tag;

  assign miss     = (state == st_idle) && !rd_valid;
  assign accepted = (state == st_request) && (mem2proc_response != '0);
  assign wr_en    = (state == st_wait_fill) && (mem2proc_tag == pend_tag);

  // Load repeats every cycle until memory takes it
  assign proc2mem_command = (state == st_request) ? bus_load : bus_none;
  assign proc2mem_addr    = {48'h0, miss_tag, miss_idx, 3'b000};

  // Forward the returning block when fetch is still waiting on it
  assign fill_match  = wr_en && (rd_idx == miss_idx) && (rd_tag == miss_tag);
  assign block_data  = fill_match ? mem2proc_data : rd_data;
  assign block_valid = rd_valid || fill_match;

  always_comb begin
    next_state = state;
    case (state)
      st_idle: begin
        if (miss) begin
          next_state = st_request;
        end
      end
      st_request: begin
        if (accepted) begin
          next_state = st_wait_fill;
        end
      end
      st_wait_fill: begin
        if (wr_en) begin
          next_state = st_idle;
        end
      end
      default: next_state = st_idle;
    endcase
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      state <= st_idle;
    end else begin
      state <= next_state;
    end
  end

  always_ff @(posedge clock) begin
    if (miss) begin
      miss_idx <= rd_idx;
      miss_tag <= rd_tag;
    end
    if (accepted) begin
      pend_tag <= mem2proc_response;
    end
  end

  // Never load a block the array already holds
  a_load_on_miss: assert property (@(posedge clock) disable iff (!rst_n)
    (proc2mem_command == bus_load && rd_idx == miss_idx && rd_tag == miss_tag) |-> !rd_valid)
    else $error("icache_ctrl: load issued for a block the cache holds");

endmodule

/* src/icache_mem.sv */
module icache_mem import fetch_pkg::*; (
  input  logic       clock,
  input  logic       rst_n,
  input  logic       wr_en,
  input  cache_idx_t wr_idx,
  input  cache_tag_t wr_tag,
  input  block_t     wr_data,
  input  cache_idx_t rd_idx,
  input  cache_tag_t rd_tag,
  output block_t     rd_data,
  output logic       rd_valid
);

  block_t               data_q [num_lines];
  cache_tag_t           tag_q  [num_lines];
  logic [num_lines-1:0] valid_q;

  // Line becomes valid on fill
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (wr_en) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (wr_en) begin
      data_q[wr_idx] <= wr_data;
      tag_q[wr_idx]  <= wr_tag;
    end
  end

  // Combinational lookup
  assign rd_data  = data_q[rd_idx];
  assign rd_valid = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);

endmodule

/* src/fetch_pkg.sv */
package fetch_pkg;

  localparam int num_lines   = 32;
  localparam int fb_depth    = 8;
  localparam int fetch_width = 2;

  // Address and data widths
  typedef logic [63:0] addr_t;
  typedef logic [31:0] inst_t;
  typedef logic [63:0] block_t;    // Lower word at lower address

  // Memory transaction tag, zero means none
  typedef logic [3:0]  mem_tag_t;

  // Cache address split: tag [15:8], index [7:3], offset [2:0]
  typedef logic [4:0]  cache_idx_t;
  typedef logic [7:0]  cache_tag_t;

  // Fetch buffer bookkeeping
  typedef logic [2:0]  fb_ptr_t;
  typedef logic [3:0]  fb_cnt_t;   // Holds 0 to fb_depth

  localparam addr_t reset_pc = 64'h0;

  typedef enum logic [1:0] {
    bus_none = 2'h0,
    bus_load = 2'h1
  } bus_cmd_e;

  typedef enum logic [1:0] {
    st_idle      = 2'h0,
    st_request   = 2'h1,
    st_wait_fill = 2'h2
  } ctrl_state_e;

endpackage
